/* design/npu_macros.svh */
`ifndef NPU_MACROS_SVH
`define NPU_MACROS_SVH

// full instruction word and opcode slice
`define INST_W 128
`define OPCODE_W 5

// on-chip buffer start addresses
`define ADDR_W 16
// weight and bias buffers are smaller
`define WB_ADDR_W 12

// jump target in the instruction stream
`define PC_W 12

// lengths, counts and line sizes
`define LEN_W 8
// external dma addresses and line counts
`define XFER_W 32

`endif

/* design/npu_isa_pkg.sv */
`include "npu_macros.svh"

package npu_isa_pkg;

	// legal opcodes, everything else is flagged as an error
	typedef enum logic [`OPCODE_W-1:0] {
		OP_DMA   = 5'b10010,
		OP_IOB2N = 5'b01010,
		OP_WB2N  = 5'b01011,
		OP_N2IOB = 5'b01101,
		OP_STOP  = 5'b11111,
		OP_JUMP  = 5'b11100
	} opcode_e;

	// dma transfer setup
	typedef struct packed {
		logic [`OPCODE_W-1:0] opcode;
		logic                 rsvd_hi;
		logic [`XFER_W-1:0]   src_start;
		logic [`XFER_W-1:0]   dest_start;
		logic [`XFER_W-1:0]   lines;
		logic [3:0]           dma_mode;
		logic                 be_stream;
		logic                 be_noblock;
		logic [`LEN_W-1:0]    i_line_size;
		logic [1:0]           i_stride;
		logic                 rsvd_mid;
		logic [1:0]           pad_num;
		logic [6:0]           rsvd_lo;
	} dma_view_t;

	// input tile setup (iob2n)
	typedef struct packed {
		logic [`OPCODE_W-1:0] opcode;
		logic                 rsvd_hi;
		logic [`ADDR_W-1:0]   addr_start;
		logic [3:0]           mode;
		logic [`LEN_W-1:0]    x_length;
		logic [`LEN_W-1:0]    y_length;
		logic [`LEN_W-1:0]    piece_num;
		logic                 b_last_tiling;
		logic                 b_first_tiling;
		logic [`LEN_W-1:0]    part_num;
		logic [3:0]           last_part;
		logic [`LEN_W-1:0]    line_size;
		logic [`LEN_W-1:0]    avg_pool_coe;
		logic [47:0]          rsvd_lo;
	} in_view_t;

	// weights, bias, kernel geometry and quantisation
	typedef struct packed {
		logic [`OPCODE_W-1:0]  opcode;
		logic                  rsvd_hi;
		logic [`WB_ADDR_W-1:0] addr_w;
		logic [`WB_ADDR_W-1:0] addr_b;
		logic [3:0]            kernel;
		logic [1:0]            stride;
		logic [1:0]            pad;
		logic [3:0]            w_q_encode;
		logic [3:0]            i_q_encode;
		logic [3:0]            o_q_encode;
		logic [77:0]           rsvd_lo;
	} wt_view_t;

	// output tile setup (n2iob)
	typedef struct packed {
		logic [`OPCODE_W-1:0] opcode;
		logic                 rsvd_hi;
		logic [`ADDR_W-1:0]   addr_start;
		logic [`LEN_W-1:0]    x_length;
		logic [`LEN_W-1:0]    y_length;
		logic [`LEN_W-1:0]    piece_num;
		logic [`LEN_W-1:0]    jump_length;
		logic [`LEN_W-1:0]    line_size;
		logic [15:0]          all_length;
		logic [1:0]           act_mode;
		logic [47:0]          rsvd_lo;
	} out_view_t;

	// fields read straight off the word, no register behind them
	typedef struct packed {
		logic [`OPCODE_W-1:0] opcode;
		logic [`PC_W-1:0]     jump_pc;
		logic [89:0]          rsvd_hi;
		logic                 be_noblock;
		logic [19:0]          rsvd_lo;
	} ctl_view_t;

	typedef union packed {
		dma_view_t dma;
		in_view_t  in_tile;
		wt_view_t  wt;
		out_view_t out_tile;
		ctl_view_t ctl;
	} inst_word_u;

endpackage

/* design/npu_cfg_pkg.sv */
`include "npu_macros.svh"

package npu_cfg_pkg;

	typedef struct packed {
		logic [`XFER_W-1:0] src_start;
		logic [`XFER_W-1:0] dest_start;
		logic [`XFER_W-1:0] lines;
		logic [3:0]         dma_mode;
		logic               be_stream;
		logic [`LEN_W-1:0]  i_line_size;
		logic [1:0]         i_stride;
		logic [1:0]         pad_num;
	} dma_cfg_t;

	typedef struct packed {
		logic [`ADDR_W-1:0] addr_start;
		logic [3:0]         mode;
		logic [`LEN_W-1:0]  x_length;
		logic [`LEN_W-1:0]  y_length;
		logic [`LEN_W-1:0]  piece_num;
		logic               b_last_tiling;
		logic               b_first_tiling;
		logic [`LEN_W-1:0]  part_num;
		logic [3:0]         last_part;
		logic [`LEN_W-1:0]  line_size;
		logic [`LEN_W-1:0]  avg_pool_coe;
	} in_cfg_t;

	typedef struct packed {
		logic [`WB_ADDR_W-1:0] addr_w;
		logic [`WB_ADDR_W-1:0] addr_b;
		logic [3:0]            kernel;
		logic [1:0]            stride;
		logic [1:0]            pad;
		logic [3:0]            w_q_encode;
		logic [3:0]            i_q_encode;
		logic [3:0]            o_q_encode;
	} wt_cfg_t;

	typedef struct packed {
		logic [`ADDR_W-1:0] addr_start;
		logic [`LEN_W-1:0]  x_length;
		logic [`LEN_W-1:0]  y_length;
		logic [`LEN_W-1:0]  piece_num;
		logic [`LEN_W-1:0]  jump_length;
		logic [`LEN_W-1:0]  line_size;
		logic [15:0]        all_length;
		logic [1:0]         act_mode;
	} out_cfg_t;

endpackage

/* design/inst_bus_if.sv */
`timescale 1ns/1ps

interface inst_bus_if;
	import npu_isa_pkg::*;

	inst_word_u word;
	// one strobe per register bank
	logic ld_dma;
	logic ld_in;
	logic ld_wt;
	logic ld_out;
	logic clr;

	modport src (
		output word, ld_dma, ld_in, ld_wt, ld_out, clr
	);

	modport bank (
		input word, ld_dma, ld_in, ld_wt, ld_out, clr
	);

endinterface

/* design/inst_classify.sv */
`timescale 1ns/1ps
`include "npu_macros.svh"

module inst_classify (
	input  npu_isa_pkg::inst_word_u i_inst,
	input  logic                    i_inst_valid,
	input  logic                    i_clr,
	output logic                    o_err_inst,
	inst_bus_if.src                 bus
);
	import npu_isa_pkg::*;

	logic [`OPCODE_W-1:0] opcode;
	logic is_dma;
	logic is_in;
	logic is_wt;
	logic is_out;
	logic is_ctl;

	// opcode sits at the top of every view
	assign opcode = i_inst.ctl.opcode;

	always_comb
	begin
		is_dma = (opcode == OP_DMA);
		is_in  = (opcode == OP_IOB2N);
		is_wt  = (opcode == OP_WB2N);
		is_out = (opcode == OP_N2IOB);
		// stop and jump are legal but load no bank
		is_ctl = (opcode == OP_STOP) || (opcode == OP_JUMP);
	end

	assign bus.word   = i_inst;
	assign bus.ld_dma = i_inst_valid & is_dma;
	assign bus.ld_in  = i_inst_valid & is_in;
	assign bus.ld_wt  = i_inst_valid & is_wt;
	assign bus.ld_out = i_inst_valid & is_out;
	assign bus.clr    = i_clr;

	// old softmax/dot/actfun opcodes land here too
	assign o_err_inst = i_inst_valid & ~(is_dma | is_in | is_wt | is_out | is_ctl);

endmodule

/* design/dma_param_regs.sv */
`timescale 1ns/1ps

module dma_param_regs (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	inst_bus_if.bank              bus,
	output npu_cfg_pkg::dma_cfg_t o_cfg
);

	// clear takes priority over a load in the same cycle
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_cfg <= '0;
		end
		else if (bus.clr)
		begin
			o_cfg <= '0;
		end
		else if (bus.ld_dma)
		begin
			o_cfg.src_start   <= bus.word.dma.src_start;
			o_cfg.dest_start  <= bus.word.dma.dest_start;
			o_cfg.lines       <= bus.word.dma.lines;
			o_cfg.dma_mode    <= bus.word.dma.dma_mode;
			o_cfg.be_stream   <= bus.word.dma.be_stream;
			o_cfg.i_line_size <= bus.word.dma.i_line_size;
			o_cfg.i_stride    <= bus.word.dma.i_stride;
			o_cfg.pad_num     <= bus.word.dma.pad_num;
		end
	end

	// settings must hold while the dma engine runs
	hold_when_idle: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		!bus.ld_dma && !bus.clr |=> $stable(o_cfg)
	) else $error("dma_param_regs: config changed without load or clear");

endmodule

/* design/in_tile_regs.sv */
`timescale 1ns/1ps

module in_tile_regs (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	inst_bus_if.bank             bus,
	output npu_cfg_pkg::in_cfg_t o_cfg
);

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_cfg <= '0;
		end
		else if (bus.clr)
		begin
			o_cfg <= '0;
		end
		else if (bus.ld_in)
		begin
			o_cfg.addr_start     <= bus.word.in_tile.addr_start;
			o_cfg.mode           <= bus.word.in_tile.mode;
			o_cfg.x_length       <= bus.word.in_tile.x_length;
			o_cfg.y_length       <= bus.word.in_tile.y_length;
			o_cfg.piece_num      <= bus.word.in_tile.piece_num;
			// tiling position of this tile within the layer
			o_cfg.b_last_tiling  <= bus.word.in_tile.b_last_tiling;
			o_cfg.b_first_tiling <= bus.word.in_tile.b_first_tiling;
			// part bookkeeping for split channels
			o_cfg.part_num       <= bus.word.in_tile.part_num;
			o_cfg.last_part      <= bus.word.in_tile.last_part;
			o_cfg.line_size      <= bus.word.in_tile.line_size;
			o_cfg.avg_pool_coe   <= bus.word.in_tile.avg_pool_coe;
		end
	end

	hold_when_idle: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		!bus.ld_in && !bus.clr |=> $stable(o_cfg)
	) else $error("in_tile_regs: config changed without load or clear");

endmodule

/* design/wt_param_regs.sv */
`timescale 1ns/1ps

module wt_param_regs (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	inst_bus_if.bank             bus,
	output npu_cfg_pkg::wt_cfg_t o_cfg
);

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_cfg <= '0;
		end
		else if (bus.clr)
		begin
			o_cfg <= '0;
		end
		else if (bus.ld_wt)
		begin
			o_cfg.addr_w     <= bus.word.wt.addr_w;
			o_cfg.addr_b     <= bus.word.wt.addr_b;
			o_cfg.kernel     <= bus.word.wt.kernel;
			o_cfg.stride     <= bus.word.wt.stride;
			o_cfg.pad        <= bus.word.wt.pad;
			// q-encodes for weight, input and output
			o_cfg.w_q_encode <= bus.word.wt.w_q_encode;
			o_cfg.i_q_encode <= bus.word.wt.i_q_encode;
			o_cfg.o_q_encode <= bus.word.wt.o_q_encode;
		end
	end

endmodule

/* design/out_tile_regs.sv */
`timescale 1ns/1ps

module out_tile_regs (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	inst_bus_if.bank              bus,
	output npu_cfg_pkg::out_cfg_t o_cfg
);

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_cfg <= '0;
		end
		else if (bus.clr)
		begin
			o_cfg <= '0;
		end
		else if (bus.ld_out)
		begin
			o_cfg.addr_start  <= bus.word.out_tile.addr_start;
			o_cfg.x_length    <= bus.word.out_tile.x_length;
			o_cfg.y_length    <= bus.word.out_tile.y_length;
			o_cfg.piece_num   <= bus.word.out_tile.piece_num;
			// stride between stored lines
			o_cfg.jump_length <= bus.word.out_tile.jump_length;
			o_cfg.line_size   <= bus.word.out_tile.line_size;
			o_cfg.all_length  <= bus.word.out_tile.all_length;
			o_cfg.act_mode    <= bus.word.out_tile.act_mode;
		end
	end

	hold_when_idle: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		!bus.ld_out && !bus.clr |=> $stable(o_cfg)
	) else $error("out_tile_regs: config changed without load or clear");

endmodule

/* design/npu_inst_decoder.sv */
`timescale 1ns/1ps
`include "npu_macros.svh"

module npu_inst_decoder (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_clr,
	input  logic [`INST_W-1:0]    i_inst,
	input  logic                  i_inst_valid,

	output logic [`OPCODE_W-1:0]  o_opcode,
	output logic                  o_err_inst,
	output logic [`PC_W-1:0]      o_jump_pc,
	output logic                  o_be_noblock,

	output logic [`XFER_W-1:0]    o_src_start,
	output logic [`XFER_W-1:0]    o_dest_start,
	output logic [`XFER_W-1:0]    o_d_lines,
	output logic [3:0]            o_dma_mode,
	output logic                  o_be_stream,
	output logic [`LEN_W-1:0]     o_dma_i_line_size,
	output logic [1:0]            o_dma_i_stride,
	output logic [1:0]            o_dma_i_pad_num,

	output logic [`ADDR_W-1:0]    o_addr_start_d,
	output logic [3:0]            o_mode,
	output logic [`LEN_W-1:0]     o_i_x_length,
	output logic [`LEN_W-1:0]     o_i_y_length,
	output logic [`LEN_W-1:0]     o_i_piece_num,
	output logic                  o_b_last_tiling,
	output logic                  o_b_first_tiling,
	output logic [`LEN_W-1:0]     o_part_num,
	output logic [3:0]            o_last_part,
	output logic [`LEN_W-1:0]     o_i_line_size,
	output logic [`LEN_W-1:0]     o_avg_pool_coe,

	output logic [`WB_ADDR_W-1:0] o_addr_start_w,
	output logic [`WB_ADDR_W-1:0] o_addr_start_b,
	output logic [3:0]            o_kernel,
	output logic [1:0]            o_stride,
	output logic [1:0]            o_pad,
	output logic [3:0]            o_w_q_encode,
	output logic [3:0]            o_i_q_encode,
	output logic [3:0]            o_o_q_encode,

	output logic [`ADDR_W-1:0]    o_addr_start_s,
	output logic [`LEN_W-1:0]     o_o_x_length,
	output logic [`LEN_W-1:0]     o_o_y_length,
	output logic [`LEN_W-1:0]     o_o_piece_num,
	output logic [`LEN_W-1:0]     o_jump_length,
	output logic [`LEN_W-1:0]     o_o_line_size,
	output logic [15:0]           o_s_all_length,
	output logic [1:0]            o_act_mode
);
	import npu_isa_pkg::*;
	import npu_cfg_pkg::*;

	inst_word_u inst_w;
	dma_cfg_t   dma_cfg;
	in_cfg_t    in_cfg;
	wt_cfg_t    wt_cfg;
	out_cfg_t   out_cfg;

	inst_bus_if bus_if ();

	assign inst_w = i_inst;

	inst_classify u_classify (
		.i_inst       (inst_w),
		.i_inst_valid (i_inst_valid),
		.i_clr        (i_clr),
		.o_err_inst   (o_err_inst),
		.bus          (bus_if.src)
	);

	dma_param_regs u_dma_regs (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.bus     (bus_if.bank),
		.o_cfg   (dma_cfg)
	);

	in_tile_regs u_in_regs (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.bus     (bus_if.bank),
		.o_cfg   (in_cfg)
	);

	wt_param_regs u_wt_regs (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.bus     (bus_if.bank),
		.o_cfg   (wt_cfg)
	);

	out_tile_regs u_out_regs (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.bus     (bus_if.bank),
		.o_cfg   (out_cfg)
	);

	// unregistered, valid in the same cycle as the word
	assign o_opcode     = inst_w.ctl.opcode;
	assign o_jump_pc    = inst_w.ctl.jump_pc;
	assign o_be_noblock = inst_w.ctl.be_noblock;

	assign o_src_start       = dma_cfg.src_start;
	assign o_dest_start      = dma_cfg.dest_start;
	assign o_d_lines         = dma_cfg.lines;
	assign o_dma_mode        = dma_cfg.dma_mode;
	assign o_be_stream       = dma_cfg.be_stream;
	assign o_dma_i_line_size = dma_cfg.i_line_size;
	assign o_dma_i_stride    = dma_cfg.i_stride;
	assign o_dma_i_pad_num   = dma_cfg.pad_num;

	assign o_addr_start_d   = in_cfg.addr_start;
	assign o_mode           = in_cfg.mode;
	assign o_i_x_length     = in_cfg.x_length;
	assign o_i_y_length     = in_cfg.y_length;
	assign o_i_piece_num    = in_cfg.piece_num;
	assign o_b_last_tiling  = in_cfg.b_last_tiling;
	assign o_b_first_tiling = in_cfg.b_first_tiling;
	assign o_part_num       = in_cfg.part_num;
	assign o_last_part      = in_cfg.last_part;
	assign o_i_line_size    = in_cfg.line_size;
	assign o_avg_pool_coe   = in_cfg.avg_pool_coe;

	assign o_addr_start_w = wt_cfg.addr_w;
	assign o_addr_start_b = wt_cfg.addr_b;
	assign o_kernel       = wt_cfg.kernel;
	assign o_stride       = wt_cfg.stride;
	assign o_pad          = wt_cfg.pad;
	assign o_w_q_encode   = wt_cfg.w_q_encode;
	assign o_i_q_encode   = wt_cfg.i_q_encode;
	assign o_o_q_encode   = wt_cfg.o_q_encode;

	assign o_addr_start_s = out_cfg.addr_start;
	assign o_o_x_length   = out_cfg.x_length;
	assign o_o_y_length   = out_cfg.y_length;
	assign o_o_piece_num  = out_cfg.piece_num;
	assign o_jump_length  = out_cfg.jump_length;
	assign o_o_line_size  = out_cfg.line_size;
	assign o_s_all_length = out_cfg.all_length;
	assign o_act_mode     = out_cfg.act_mode;

endmodule

/* tb/tb_npu_inst_decoder.sv */
`timescale 1ns/1ps

module tb_npu_inst_decoder;

	localparam int RESET_CYCLES = 16;
	localparam int RAND_CYCLES  = 480;
	// reset, directed and random cycles, with generous margin
	localparam int STIM_CYCLES  = 600;
	localparam int MAX_CYCLES   = 5 * STIM_CYCLES;

	// six legal opcodes first, then a few that must be flagged
	localparam logic [4:0] OP_LIST [10] = '{
		5'b10010, 5'b01010, 5'b01011, 5'b01101, 5'b11111,
		5'b11100, 5'b00000, 5'b10100, 5'b11000, 5'b00110
	};

	logic         i_clk;
	logic         i_rst_n;
	logic         i_clr;
	logic [127:0] i_inst;
	logic         i_inst_valid;

	logic [4:0]  o_opcode;
	logic        o_err_inst;
	logic [11:0] o_jump_pc;
	logic        o_be_noblock;
	logic [31:0] o_src_start, o_dest_start, o_d_lines;
	logic [3:0]  o_dma_mode, o_mode, o_last_part, o_kernel;
	logic        o_be_stream, o_b_last_tiling, o_b_first_tiling;
	logic [7:0]  o_dma_i_line_size, o_i_x_length, o_i_y_length, o_i_piece_num;
	logic [1:0]  o_dma_i_stride, o_dma_i_pad_num, o_stride, o_pad, o_act_mode;
	logic [15:0] o_addr_start_d, o_addr_start_s, o_s_all_length;
	logic [7:0]  o_part_num, o_i_line_size, o_avg_pool_coe;
	logic [11:0] o_addr_start_w, o_addr_start_b;
	logic [3:0]  o_w_q_encode, o_i_q_encode, o_o_q_encode;
	logic [7:0]  o_o_x_length, o_o_y_length, o_o_piece_num, o_jump_length, o_o_line_size;

	logic [112:0] exp_dma, act_dma;
	logic [73:0]  exp_in, act_in;
	logic [43:0]  exp_wt, act_wt;
	logic [73:0]  exp_out, act_out;

	integer seed;
	int     cycle_count;
	int     n_dma, n_in, n_wt, n_out, n_err, n_ctl, n_idle, n_clr_ld;

	npu_inst_decoder i_npu_inst_decoder (.*);

	initial
	begin
		i_clk = 1'b0;
		forever
		begin
			#50 i_clk = ~i_clk;
		end
	end

	// field positions per instruction class
	function automatic logic [112:0] dma_fields(input logic [127:0] w);
		return {w[121:90], w[89:58], w[57:26], w[25:22], w[21], w[19:12], w[11:10], w[8:7]};
	endfunction

	function automatic logic [73:0] in_fields(input logic [127:0] w);
		return {w[121:106], w[105:102], w[101:94], w[93:86], w[85:78], w[77], w[76],
			w[75:68], w[67:64], w[63:56], w[55:48]};
	endfunction

	function automatic logic [43:0] wt_fields(input logic [127:0] w);
		return {w[121:110], w[109:98], w[97:94], w[93:92], w[91:90], w[89:78]};
	endfunction

	function automatic logic [73:0] out_fields(input logic [127:0] w);
		return {w[121:106], w[105:98], w[97:90], w[89:82], w[81:74], w[73:66], w[65:50],
			w[49:48]};
	endfunction

	function automatic logic err_expected(input logic valid, input logic [4:0] op);
		case (op)
			5'b10010, 5'b01010, 5'b01011, 5'b01101, 5'b11111, 5'b11100: return 1'b0;
			default: return valid;
		endcase
	endfunction

	assign act_dma = {o_src_start, o_dest_start, o_d_lines, o_dma_mode, o_be_stream,
		o_dma_i_line_size, o_dma_i_stride, o_dma_i_pad_num};
	assign act_in = {o_addr_start_d, o_mode, o_i_x_length, o_i_y_length, o_i_piece_num,
		o_b_last_tiling, o_b_first_tiling, o_part_num, o_last_part, o_i_line_size,
		o_avg_pool_coe};
	assign act_wt = {o_addr_start_w, o_addr_start_b, o_kernel, o_stride, o_pad,
		o_w_q_encode, o_i_q_encode, o_o_q_encode};
	assign act_out = {o_addr_start_s, o_o_x_length, o_o_y_length, o_o_piece_num,
		o_jump_length, o_o_line_size, o_s_all_length, o_act_mode};

	// reference copy of each bank, clear beats a load
	always @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n || i_clr)
		begin
			exp_dma <= '0;
			exp_in  <= '0;
			exp_wt  <= '0;
			exp_out <= '0;
		end
		else if (i_inst_valid)
		begin
			case (i_inst[127:123])
				5'b10010: exp_dma <= dma_fields(i_inst);
				5'b01010: exp_in  <= in_fields(i_inst);
				5'b01011: exp_wt  <= wt_fields(i_inst);
				5'b01101: exp_out <= out_fields(i_inst);
				default: ;
			endcase
		end
	end

	task automatic report_mismatch(input string name, input logic [319:0] expv,
		input logic [319:0] actv);
		$display("FAIL %s expected %0h actual %0h", name, expv, actv);
		$display("tests failed");
		$fatal(1, "check %s did not hold", name);
	endtask

	reset_zero: assert property (@(posedge i_clk)
		$rose(i_rst_n) |-> ({act_dma, act_in, act_wt, act_out} == '0))
		else report_mismatch("reset_zero", '0,
			320'($sampled({act_dma, act_in, act_wt, act_out})));

	dma_bank: assert property (@(posedge i_clk) disable iff (!i_rst_n) act_dma == exp_dma)
		else report_mismatch("dma_bank", 320'($sampled(exp_dma)), 320'($sampled(act_dma)));

	in_bank: assert property (@(posedge i_clk) disable iff (!i_rst_n) act_in == exp_in)
		else report_mismatch("in_bank", 320'($sampled(exp_in)), 320'($sampled(act_in)));

	wt_bank: assert property (@(posedge i_clk) disable iff (!i_rst_n) act_wt == exp_wt)
		else report_mismatch("wt_bank", 320'($sampled(exp_wt)), 320'($sampled(act_wt)));

	out_bank: assert property (@(posedge i_clk) disable iff (!i_rst_n) act_out == exp_out)
		else report_mismatch("out_bank", 320'($sampled(exp_out)), 320'($sampled(act_out)));

	err_flag: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_err_inst == err_expected(i_inst_valid, i_inst[127:123]))
		else report_mismatch("err_flag",
			320'(err_expected($sampled(i_inst_valid), $sampled(i_inst[127:123]))),
			320'($sampled(o_err_inst)));

	// opcode, jump target and no-block bit come straight off the word
	ctl_fields: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		{o_opcode, o_jump_pc, o_be_noblock} == {i_inst[127:111], i_inst[20]})
		else report_mismatch("ctl_fields", 320'({$sampled(i_inst[127:111]), $sampled(i_inst[20])}),
			320'($sampled({o_opcode, o_jump_pc, o_be_noblock})));

	// count what the stimulus reached
	always @(posedge i_clk)
	begin
		cycle_count <= cycle_count + 1;
		if (i_rst_n)
		begin
			if (i_inst_valid && !i_clr && i_inst[127:123] == 5'b10010) n_dma <= n_dma + 1;
			if (i_inst_valid && !i_clr && i_inst[127:123] == 5'b01010) n_in <= n_in + 1;
			if (i_inst_valid && !i_clr && i_inst[127:123] == 5'b01011) n_wt <= n_wt + 1;
			if (i_inst_valid && !i_clr && i_inst[127:123] == 5'b01101) n_out <= n_out + 1;
			if (i_inst_valid && i_inst[127:125] == 3'b111) n_ctl <= n_ctl + 1;
			if (o_err_inst) n_err <= n_err + 1;
			if (!i_inst_valid) n_idle <= n_idle + 1;
			if (i_clr && i_inst_valid && i_inst[127:123] == 5'b10010) n_clr_ld <= n_clr_ld + 1;
		end
		if (cycle_count >= MAX_CYCLES)
		begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("tests failed");
			$fatal(1, "timeout");
		end
	end

	task automatic drive_cycle(input logic valid, input logic [4:0] op, input logic clr);
		logic [127:0] w;
		@(negedge i_clk);
		w = {$random(seed), $random(seed), $random(seed), $random(seed)};
		w[127:123] = op;
		i_inst       = w;
		i_inst_valid = valid;
		i_clr        = clr;
	endtask

	initial
	begin
		integer r;
		seed = 32'h30685a7b;
		cycle_count = 0;
		{n_dma, n_in, n_wt, n_out, n_err, n_ctl, n_idle, n_clr_ld} = '0;
		i_rst_n      = 1'b0;
		i_clr        = 1'b0;
		i_inst       = '0;
		i_inst_valid = 1'b0;
		repeat (RESET_CYCLES) @(negedge i_clk);
		i_rst_n = 1'b1;
		drive_cycle(1'b0, 5'b00000, 1'b0);
		// one load per bank, then idle words and control opcodes
		for (int i = 0; i < 4; i++)
		begin
			drive_cycle(1'b1, OP_LIST[i], 1'b0);
		end
		drive_cycle(1'b0, 5'b10010, 1'b0);
		drive_cycle(1'b0, 5'b01011, 1'b0);
		drive_cycle(1'b1, 5'b11111, 1'b0);
		drive_cycle(1'b1, 5'b11100, 1'b0);
		// illegal opcodes, with and without valid
		for (int i = 6; i < 10; i++)
		begin
			drive_cycle(1'b1, OP_LIST[i], 1'b0);
			drive_cycle(1'b0, OP_LIST[i], 1'b0);
		end
		drive_cycle(1'b0, 5'b00000, 1'b1);
		drive_cycle(1'b1, 5'b10010, 1'b0);
		drive_cycle(1'b1, 5'b10010, 1'b1);
		for (int i = 0; i < RAND_CYCLES; i++)
		begin
			r = $random(seed);
			drive_cycle(r[9:8] != 2'b00, OP_LIST[r[7:0] % 10], r[13:10] == 4'hf);
		end
		drive_cycle(1'b0, 5'b00000, 1'b0);
		drive_cycle(1'b0, 5'b00000, 1'b0);
		@(negedge i_clk);
		if (n_dma == 0 || n_in == 0 || n_wt == 0 || n_out == 0 || n_err == 0 || n_ctl == 0
			|| n_idle == 0 || n_clr_ld == 0)
		begin
			$display("stimulus missed a behavior: dma %0d in %0d wt %0d out %0d err %0d",
				n_dma, n_in, n_wt, n_out, n_err);
			$display("tests failed");
			$fatal(1, "coverage hole");
		end
		else
		begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

/* npu_inst_decoder.f */
+incdir+design
design/npu_isa_pkg.sv
design/npu_cfg_pkg.sv
design/inst_bus_if.sv
design/inst_classify.sv
design/dma_param_regs.sv
design/in_tile_regs.sv
design/wt_param_regs.sv
design/out_tile_regs.sv
design/npu_inst_decoder.sv
tb/tb_npu_inst_decoder.sv

/* run_sim.sh */
#!/bin/sh
verilator --binary --timing --assert -f npu_inst_decoder.f --top-module tb_npu_inst_decoder \
	-o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "all tests passed" sim.log || exit 1
grep -q "tests failed" sim.log && exit 1 || exit 0
